// ==== hw/pm_pkg.sv ====
`default_nettype none

package pm_pkg;

   ////////////////////
   // Sizes

   // Pattern length in bytes, byte 0 is the newest
   localparam int PM_PATTERN_BYTES = 8;
   // History held besides the current byte
   localparam int PM_WINDOW_BITS = (PM_PATTERN_BYTES - 1) * 8;

   ////////////////////
   // Plain vectors

   typedef logic [7:0] fe_byte_t;
   typedef logic [PM_PATTERN_BYTES*8-1:0] pattern_vec_t;
   typedef logic [7:0] byte_count_t;
   typedef logic [15:0] match_count_t;

   ////////////////////
   // Structs

   // Feeder to lanes, one per cycle
   typedef struct packed {
      logic strobe;
      fe_byte_t data;
      logic [PM_WINDOW_BITS-1:0] window;
      byte_count_t count;
      logic capture_done;
      logic arm_start;
   } fe_beat_t;

   // Per-lane setup, 137 bits
   typedef struct packed {
      pattern_vec_t pattern;
      pattern_vec_t mask;
      byte_count_t pattern_bytes;
      logic enable;
   } lane_cfg_t;

endpackage

`default_nettype wire

// ==== hw/pm_byte_feeder.sv ====
`default_nettype none

module pm_byte_feeder import pm_pkg::*; (
   input  wire            fe_clk,
   input  wire            reset_i,
   input  wire            arm,
   input  wire fe_byte_t  fe_data,
   input  wire            fe_data_valid,
   input  wire            capturing,
   input  wire            lane_level_any,
   output fe_beat_t       beat
);

   // Arm delay chain, third flop only for edge detect
   logic arm_d1;
   logic arm_d2;
   logic arm_d3;

   logic capturing_q;
   logic capture_fall;
   logic history_clear;
   logic armed_valid;

   // Shared history, newest byte in the low bits
   logic [PM_WINDOW_BITS-1:0] window_q;
   byte_count_t count_q;

   ////////////////////
   // Qualifiers

   assign capture_fall = capturing_q & ~capturing;
   // End of capture with some lane still matched
   assign history_clear = capture_fall & lane_level_any;
   // Byte dropped on the clearing cycle so all lanes agree
   assign armed_valid = fe_data_valid & arm_d2 & ~history_clear;

   ////////////////////
   // History and count

   always_ff @(posedge fe_clk) begin
      if (reset_i) begin
         arm_d1 <= 1'b0;
         arm_d2 <= 1'b0;
         arm_d3 <= 1'b0;
         capturing_q <= 1'b0;
         window_q <= '0;
         count_q <= '0;
      end else begin
         arm_d1 <= arm;
         arm_d2 <= arm_d1;
         arm_d3 <= arm_d2;
         capturing_q <= capturing;
         if (history_clear) begin
            window_q <= '0;
            count_q <= '0;
         end else if (armed_valid) begin
            window_q <= {window_q[PM_WINDOW_BITS-9:0], fe_data};
            // Saturate at 255
            if (count_q != '1)
               count_q <= count_q + 8'd1;
         end
      end
   end

   ////////////////////
   // Broadcast

   always_comb begin
      beat.strobe = armed_valid;
      beat.data = fe_data;
      beat.window = window_q;
      // Bytes before the current one
      beat.count = count_q;
      beat.capture_done = capture_fall;
      beat.arm_start = arm_d2 & ~arm_d3;
   end

endmodule

`default_nettype wire

// ==== hw/pm_match_lane.sv ====
`default_nettype none

module pm_match_lane import pm_pkg::*; (
   input  wire             fe_clk,
   input  wire             reset_i,
   input  wire fe_beat_t   beat,
   input  wire lane_cfg_t  cfg,
   output logic            level,
   output logic            pulse
);

   // Current byte joined below the stored history
   pattern_vec_t observed;
   pattern_vec_t masked_observed;
   pattern_vec_t masked_pattern;

   // Widened so pattern_bytes of 0 does not wrap
   logic [8:0] bytes_seen;
   logic [8:0] bytes_needed;
   logic bytes_enough;

   logic pattern_equal;
   logic hit;

   // Previous level for edge detect
   logic level_q;

   ////////////////////
   // Compare

   assign observed = {beat.window, beat.data};

   // Masked bits drop out on both sides
   assign masked_observed = observed & cfg.mask;
   assign masked_pattern = cfg.pattern & cfg.mask;

   assign pattern_equal = (masked_observed == masked_pattern);

   // Current byte counts toward the length
   assign bytes_seen = {1'b0, beat.count} + 9'd1;
   assign bytes_needed = {1'b0, cfg.pattern_bytes};
   assign bytes_enough = (bytes_seen >= bytes_needed);

   // Disabled lane never matches
   assign hit = cfg.enable & pattern_equal & bytes_enough;

   ////////////////////
   // Match level

   always_ff @(posedge fe_clk) begin
      if (reset_i) begin
         level <= 1'b0;
         level_q <= 1'b0;
      end else begin
         level_q <= level;
         // Capture end wipes a held match
         if (beat.capture_done && level)
            level <= 1'b0;
         // Rewritten by every armed byte
         else if (beat.strobe)
            level <= hit;
      end
   end

   ////////////////////
   // Rising edge

   // High for the cycle after the matching byte
   assign pulse = level & ~level_q;

endmodule

`default_nettype wire

// ==== hw/pm_trigger_combiner.sv ====
`default_nettype none

module pm_trigger_combiner import pm_pkg::*; #(
   parameter int NUM_LANES = 4
) (
   input  wire                  fe_clk,
   input  wire                  reset_i,
   input  wire [NUM_LANES-1:0]  lane_pulse,
   input  wire                  arm_start,
   output logic                 trigger,
   output logic [NUM_LANES-1:0] hit_lanes,
   output match_count_t         match_count
);

   // Any lane fired this cycle
   logic any_pulse;

   // Record bases, zero on a fresh arming
   logic [NUM_LANES-1:0] hit_base;
   match_count_t count_base;
   logic count_full;

   ////////////////////
   // Merge

   assign any_pulse = |lane_pulse;

   assign hit_base = arm_start ? '0 : hit_lanes;
   assign count_base = arm_start ? '0 : match_count;

   // Saturate at all ones
   assign count_full = (count_base == '1);

   ////////////////////
   // Trigger and records

   always_ff @(posedge fe_clk) begin
      if (reset_i) begin
         trigger <= 1'b0;
         hit_lanes <= '0;
         match_count <= '0;
      end else begin
         // One cycle late, one cycle wide
         trigger <= any_pulse;
         // Sticky per lane until next arming
         hit_lanes <= hit_base | lane_pulse;
         // One step per trigger cycle
         if (any_pulse && !count_full)
            match_count <= count_base + 16'd1;
         else
            match_count <= count_base;
      end
   end

endmodule

`default_nettype wire

// ==== hw/pm_trigger_top.sv ====
`default_nettype none

module pm_trigger_top import pm_pkg::*; #(
   parameter int NUM_LANES = 4
) (
   input  wire                             fe_clk,
   input  wire                             reset_i,
   input  wire                             arm,
   input  wire lane_cfg_t [NUM_LANES-1:0]  lane_cfg,
   input  wire fe_byte_t                   fe_data,
   input  wire                             fe_data_valid,
   input  wire                             capturing,
   output logic                            trigger,
   output logic [NUM_LANES-1:0]            hit_lanes,
   output match_count_t                    match_count
);

   // Shared history to every lane
   fe_beat_t beat;

   logic [NUM_LANES-1:0] lane_level;
   logic [NUM_LANES-1:0] lane_pulse;
   // Some lane still holds a match
   logic lane_level_any;

   assign lane_level_any = |lane_level;

   ////////////////////
   // Front end

   pm_byte_feeder u_feeder (
      .fe_clk         (fe_clk),
      .reset_i        (reset_i),
      .arm            (arm),
      .fe_data        (fe_data),
      .fe_data_valid  (fe_data_valid),
      .capturing      (capturing),
      .lane_level_any (lane_level_any),
      .beat           (beat)
   );

   ////////////////////
   // Lanes

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      pm_match_lane u_lane (
         .fe_clk  (fe_clk),
         .reset_i (reset_i),
         .beat    (beat),
         .cfg     (lane_cfg[i]),
         .level   (lane_level[i]),
         .pulse   (lane_pulse[i])
      );
   end

   ////////////////////
   // Combine

   pm_trigger_combiner #(
      .NUM_LANES (NUM_LANES)
   ) u_combiner (
      .fe_clk      (fe_clk),
      .reset_i     (reset_i),
      .lane_pulse  (lane_pulse),
      .arm_start   (beat.arm_start),
      .trigger     (trigger),
      .hit_lanes   (hit_lanes),
      .match_count (match_count)
   );

endmodule

`default_nettype wire

// ==== test/pm_trigger_monitor.sv ====
`default_nettype none

module pm_trigger_monitor import pm_pkg::*; #(
   parameter int NUM_LANES = 4
) (
   input  wire                  fe_clk,
   input  wire                  reset_i,
   input  wire                  trigger,
   input  wire [NUM_LANES-1:0]  hit_lanes,
   input  wire match_count_t    match_count,
   input  wire                  exp_strobe,
   input  wire fe_byte_t        exp_data,
   input  wire                  exp_trigger,
   input  wire [NUM_LANES-1:0]  exp_hit,
   input  wire                  count_strobe,
   input  wire match_count_t    exp_count,
   output logic                 busy,
   output int                   errors
);
   timeunit 1ns;
   timeprecision 1ps;

   // One byte's expectation in flight
   typedef struct packed {
      logic valid;
      fe_byte_t data;
      logic trig;
      logic [NUM_LANES-1:0] hit;
   } expect_t;

   // Stage 1 at edge E, stage 2 at E+1
   expect_t stage1;
   expect_t stage2;
   logic count_req;
   match_count_t count_exp;
   int err_count = 0;

   assign errors = err_count;
   assign busy = exp_strobe | stage1.valid | stage2.valid | count_strobe | count_req;

   always_ff @(posedge fe_clk) begin
      if (reset_i) begin
         stage1 <= '0;
         stage2 <= '0;
         count_req <= 1'b0;
         count_exp <= '0;
      end else begin
         stage1 <= {exp_strobe, exp_data, exp_trigger, exp_hit};
         stage2 <= stage1;
         count_req <= count_strobe;
         count_exp <= exp_count;
      end
   end

   ////////////////////
   // Compare

   // Mid-cycle, outputs settled since E+1
   always @(negedge fe_clk) begin
      if (!reset_i) begin
         if (stage2.valid) begin
            if (trigger !== stage2.trig) begin
               $display("mismatch at %0t: byte %h trigger %b expected %b",
                        $time, stage2.data, trigger, stage2.trig);
               err_count++;
            end
            if (hit_lanes !== stage2.hit) begin
               $display("mismatch at %0t: byte %h hit_lanes %h expected %h",
                        $time, stage2.data, hit_lanes, stage2.hit);
               err_count++;
            end
         end else if (trigger !== 1'b0) begin
            // Only a byte two edges back may fire
            $display("mismatch at %0t: trigger %b with no byte pending", $time, trigger);
            err_count++;
         end
         if (count_req && match_count !== count_exp) begin
            $display("mismatch at %0t: match_count %0d expected %0d",
                     $time, match_count, count_exp);
            err_count++;
         end
      end
   end

endmodule

`default_nettype wire

// ==== test/pm_trigger_checker.sv ====
`default_nettype none

module pm_trigger_checker import pm_pkg::*; #(
   parameter int NUM_LANES = 4
) (
   input  wire                             fe_clk,
   input  wire                             reset_i,
   input  wire                             trigger,
   input  wire                             arm_start,
   input  wire [NUM_LANES-1:0]             hit_lanes,
   input  wire [NUM_LANES-1:0]             lane_pulse,
   input  wire lane_cfg_t [NUM_LANES-1:0]  lane_cfg
);
   timeunit 1ns;
   timeprecision 1ps;

   // Assertion failures so far
   int fail_count = 0;

   // One-cycle pulse only
   a_trigger_single: assert property (@(posedge fe_clk) disable iff (reset_i)
      trigger |=> !trigger)
      else begin
         $error("trigger high two cycles in a row");
         fail_count++;
      end

   // Quiet after any reset edge
   a_trigger_reset: assert property (@(posedge fe_clk)
      $past(reset_i) |-> !trigger)
      else begin
         $error("trigger high during reset");
         fail_count++;
      end

   // Sticky bits until next arming
   a_hit_sticky: assert property (@(posedge fe_clk) disable iff (reset_i)
      !arm_start |=> ((hit_lanes & $past(hit_lanes)) == $past(hit_lanes)))
      else begin
         $error("hit_lanes lost a bit without arm_start");
         fail_count++;
      end

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane_check
      a_pulse_enabled: assert property (@(posedge fe_clk) disable iff (reset_i)
         !lane_cfg[i].enable |-> !lane_pulse[i])
         else begin
            $error("pulse on disabled lane");
            fail_count++;
         end
   end

endmodule

`default_nettype wire

// ==== test/pm_trigger_tb.sv ====
`default_nettype none

module pm_trigger_tb import pm_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_LANES = 4;
   // Cycles to wait for the monitor to drain
   localparam int DRAIN_LIMIT = 20;

   logic fe_clk;
   logic reset_i;
   logic arm;
   lane_cfg_t [NUM_LANES-1:0] lane_cfg;
   fe_byte_t fe_data;
   logic fe_data_valid;
   logic capturing;
   logic trigger;
   logic [NUM_LANES-1:0] hit_lanes;
   match_count_t match_count;

   // Expectations handed to the monitor
   logic exp_strobe;
   fe_byte_t exp_data;
   logic exp_trigger;
   logic [NUM_LANES-1:0] exp_hit;
   logic count_strobe;
   match_count_t exp_count;
   logic mon_busy;
   int mon_errors;
   int tb_errors = 0;

   pm_trigger_top #(.NUM_LANES(NUM_LANES)) dut (
      .fe_clk        (fe_clk),
      .reset_i       (reset_i),
      .arm           (arm),
      .lane_cfg      (lane_cfg),
      .fe_data       (fe_data),
      .fe_data_valid (fe_data_valid),
      .capturing     (capturing),
      .trigger       (trigger),
      .hit_lanes     (hit_lanes),
      .match_count   (match_count)
   );

   pm_trigger_monitor #(.NUM_LANES(NUM_LANES)) mon (
      .fe_clk       (fe_clk),
      .reset_i      (reset_i),
      .trigger      (trigger),
      .hit_lanes    (hit_lanes),
      .match_count  (match_count),
      .exp_strobe   (exp_strobe),
      .exp_data     (exp_data),
      .exp_trigger  (exp_trigger),
      .exp_hit      (exp_hit),
      .count_strobe (count_strobe),
      .exp_count    (exp_count),
      .busy         (mon_busy),
      .errors       (mon_errors)
   );

   bind pm_trigger_top pm_trigger_checker #(.NUM_LANES(NUM_LANES)) u_checker (
      .fe_clk     (fe_clk),
      .reset_i    (reset_i),
      .trigger    (trigger),
      .arm_start  (beat.arm_start),
      .hit_lanes  (hit_lanes),
      .lane_pulse (lane_pulse),
      .lane_cfg   (lane_cfg)
   );

   ////////////////////
   // Clock

   initial begin
      fe_clk = 1'b0;
      forever #5 fe_clk = ~fe_clk;
   end

   ////////////////////
   // Driver tasks

   // Inputs change 1 ns after the edge
   task automatic next_cycle();
      @(posedge fe_clk);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic send_byte(input fe_byte_t data, input logic trig,
                            input logic [NUM_LANES-1:0] hit);
      fe_data = data;
      fe_data_valid = 1'b1;
      exp_strobe = 1'b1;
      exp_data = data;
      exp_trigger = trig;
      exp_hit = hit;
      next_cycle();
      fe_data_valid = 1'b0;
      exp_strobe = 1'b0;
   endtask

   // Loop until every pending check has been made
   task automatic wait_drained(input string what);
      int waited;
      waited = 0;
      while (mon_busy && waited < DRAIN_LIMIT) begin
         @(negedge fe_clk);
         waited++;
      end
      if (mon_busy) begin
         $display("timeout: monitor still busy after %0d cycles at %s", DRAIN_LIMIT, what);
         tb_errors++;
      end
      next_cycle();
   endtask

   task automatic request_count_check(input match_count_t count);
      count_strobe = 1'b1;
      exp_count = count;
      next_cycle();
      count_strobe = 1'b0;
   endtask

   ////////////////////
   // Vector player

   initial begin
      int fd;
      int n;
      string line;
      string op;
      logic [63:0] f1, f2, f3, f4, f5;
      lane_cfg_t cfg;
      arm = 1'b0;
      lane_cfg = '0;
      fe_data = '0;
      fe_data_valid = 1'b0;
      capturing = 1'b0;
      exp_strobe = 1'b0;
      exp_data = '0;
      exp_trigger = 1'b0;
      exp_hit = '0;
      count_strobe = 1'b0;
      exp_count = '0;
      void'($urandom(24));
      reset_i = 1'b1;
      repeat (16) @(posedge fe_clk);
      #1;
      reset_i = 1'b0;
      fd = $fopen("test/pm_trigger_vectors.txt", "r");
      if (fd == 0) begin
         $display("cannot open vector file test/pm_trigger_vectors.txt");
         tb_errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            op = "";
            n = $fgets(line, fd);
            // Comment and blank lines leave op empty
            if (n > 1 && line[0] != "#")
               n = $sscanf(line, "%s %h %h %h %h %h", op, f1, f2, f3, f4, f5);
            if (op == "C") begin
               cfg.pattern = f4;
               cfg.mask = f5;
               cfg.pattern_bytes = f3[7:0];
               cfg.enable = f2[0];
               lane_cfg[f1[1:0]] = cfg;
            end else if (op == "A") begin
               arm = f1[0];
               next_cycle();
            end else if (op == "P") begin
               capturing = f1[0];
               next_cycle();
            end else if (op == "I") begin
               idle_cycles(int'(f1));
            end else if (op == "B") begin
               // Gaps carry no strobe, so expectations hold
               idle_cycles($urandom % 4);
               send_byte(f1[7:0], f2[0], f3[NUM_LANES-1:0]);
            end else if (op == "N") begin
               send_byte(f1[7:0], f2[0], f3[NUM_LANES-1:0]);
            end else if (op == "M") begin
               wait_drained("match count check");
               request_count_check(f1[15:0]);
            end else if (op != "") begin
               $display("unknown command %s in vector file", op);
               tb_errors++;
            end
         end
         $fclose(fd);
      end
      wait_drained("end of vectors");
      $display("closing report: errors monitor %0d testbench %0d assertions %0d",
               mon_errors, tb_errors, dut.u_checker.fail_count);
      if (mon_errors == 0 && tb_errors == 0 && dut.u_checker.fail_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/pm_trigger_vectors.txt ====
# C lane enable pattern_bytes pattern mask | A arm | P capturing | I idle | M match_count
# B data trigger hit_lanes (random gap first) | N data trigger hit_lanes (no gap), hex
C 0 1 08 1122334455667788 ffffffffffffffff
C 1 1 03 0000000000a5bcde 0000000000f0ffff
C 2 0 08 1122334455667788 ffffffffffffffff
C 3 1 05 000000000000000e 000000000000000f
P 1
A 1
I 3
B a7 0 0
B bc 0 0
B de 1 2
B 00 0 2
M 1
A 0
I 2
A 1
I 3
B 11 0 0
B 22 0 0
B 33 0 0
B 44 0 0
B 55 0 0
B 66 0 0
B 77 0 0
B 89 0 0
B 11 0 0
B 22 0 0
B 33 0 0
B 44 0 0
B 55 0 0
B 66 0 0
B 77 0 0
B 88 1 1
B 00 0 1
M 1
A 0
I 3
B 11 0 1
B 22 0 1
B 33 0 1
B 44 0 1
A 1
N 55 0 0
N 66 0 0
N 77 0 0
N 88 0 0
M 0
B ee 1 8
B ee 0 8
M 1
P 0
P 1
B 11 0 8
B 22 0 8
B 33 0 8
B 44 0 8
B ee 1 8
B 00 0 8
M 2
A 0
I 2
A 1
I 3
M 0
B a1 0 0
B bc 0 0
B de 1 a
B 00 0 a
M 1
A 0
I 2
A 1
I 3
M 0

// ==== vlog.f ====
hw/pm_pkg.sv
hw/pm_byte_feeder.sv
hw/pm_match_lane.sv
hw/pm_trigger_combiner.sv
hw/pm_trigger_top.sv
test/pm_trigger_monitor.sv
test/pm_trigger_checker.sv
test/pm_trigger_tb.sv
